// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

	// ====================
	// Address and line geometry
	// ====================
	localparam int ADDR_W      = 32;
	localparam int WORD_W      = 32;
	localparam int WORD_BYTES  = WORD_W / 8;
	localparam int LINE_WORDS  = 4;
	localparam int LINE_W      = LINE_WORDS * WORD_W;
	localparam int LINE_SEL_W  = LINE_W / 8;
	// Word offset inside a line, and byte offset of the whole line
	localparam int OFF_W       = $clog2(LINE_WORDS);
	localparam int LINE_OFF_W  = $clog2(LINE_SEL_W);

	// L1 fields
	localparam int L1_LINES    = 16;
	localparam int L1_IDX_W    = $clog2(L1_LINES);
	localparam int L1_TAG_W    = ADDR_W - L1_IDX_W - LINE_OFF_W;

	// L2 fields and lookup pipeline
	localparam int L2_LINES    = 64;
	localparam int L2_IDX_W    = $clog2(L2_LINES);
	localparam int L2_TAG_W    = ADDR_W - L2_IDX_W - LINE_OFF_W;
	localparam int L2_READ_LAT = 2;
	localparam int L2_CNT_W    = $clog2(L2_READ_LAT + 1);

	// Boot ROM sits where the upper address half is all ones
	localparam int ROM_HI_W    = 16;
	localparam logic [ROM_HI_W-1:0] ROM_BASE_HI = '1;
	localparam int ROM_LINES   = 16;
	localparam int ROM_IDX_W   = $clog2(ROM_LINES);

	// Bus line fill counter
	localparam int FILL_CNT_W  = 32;

	// ====================
	// Enums
	// ====================
	typedef enum logic [2:0] {
		DC_IDLE, DC_INVAL, DC_L2_WAIT, DC_L2_CHECK, DC_ROM, DC_BUS, DC_FILL, DC_DONE
	} dc_state_e;

	// Wishbone cycle type identifiers
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'b000,
		CTI_INCR    = 3'b010,
		CTI_END     = 3'b111
	} cti_e;

endpackage

// ==== verilog/dc_request_stage.sv ====
`timescale 1ns/1ns
module dc_request_stage import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [ADDR_W-1:0]     adr_i,
	input  logic [WORD_W-1:0]     wdat_i,
	input  logic [WORD_BYTES-1:0] wsel_i,
	input  logic                  inv_i,
	input  logic [ADDR_W-1:0]     inv_adr_i,
	input  logic                  inv_take_i,
	output logic [ADDR_W-1:0]     line_adr_o,
	output logic [OFF_W-1:0]      word_off_o,
	output logic [LINE_W-1:0]     st_line_o,
	output logic [LINE_SEL_W-1:0] st_sel_o,
	output logic                  inv_pend_o,
	output logic [ADDR_W-1:0]     inv_line_o
);

// Request address split into line base and word slot
assign line_adr_o = {adr_i[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
assign word_off_o = adr_i[LINE_OFF_W-1 -: OFF_W];

// Store word and byte enables moved into their slot of the line
assign st_line_o = LINE_W'(wdat_i) << (word_off_o * WORD_W);
assign st_sel_o  = LINE_SEL_W'(wsel_i) << (word_off_o * WORD_BYTES);

// ====================
// Invalidate latch
// ====================
// A new pulse wins over a take in the same cycle
always_ff @(posedge clk) begin
	if (rst_i) begin
		inv_pend_o <= 1'b0;
	end else if (inv_i) begin
		inv_pend_o <= 1'b1;
	end else if (inv_take_i) begin
		inv_pend_o <= 1'b0;
	end
end

// Line address of the latest request
always_ff @(posedge clk) begin
	if (inv_i)
		inv_line_o <= {inv_adr_i[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
end

endmodule

// ==== verilog/dl1_store.sv ====
`timescale 1ns/1ns
module dl1_store import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [L1_IDX_W-1:0]   index_i,
	input  logic [L1_TAG_W-1:0]   tag_i,
	input  logic                  wr_i,
	input  logic [LINE_SEL_W-1:0] wsel_i,
	input  logic [LINE_W-1:0]     wline_i,
	input  logic                  inv_i,
	output logic                  hit_o,
	output logic [LINE_W-1:0]     line_o
);

// ====================
// Storage
// ====================
logic [L1_TAG_W-1:0] tag_mem  [L1_LINES];
logic [LINE_W-1:0]   line_mem [L1_LINES];
logic [L1_LINES-1:0] valid;

// Lookup is purely combinational
assign hit_o  = valid[index_i] && (tag_mem[index_i] == tag_i);
assign line_o = line_mem[index_i];

// Valid bits
always_ff @(posedge clk) begin
	if (rst_i) begin
		valid <= '0;
	end else if (inv_i) begin
		valid[index_i] <= 1'b0;
	end else if (wr_i) begin
		// Any write claims the entry
		valid[index_i] <= 1'b1;
	end
end

// Tag and data
always_ff @(posedge clk) begin
	if (wr_i && !inv_i) begin
		tag_mem[index_i] <= tag_i;
		// Merge only the selected bytes
		for (int b = 0; b < LINE_SEL_W; b++) begin
			if (wsel_i[b])
				line_mem[index_i][b*8 +: 8] <= wline_i[b*8 +: 8];
		end
	end
end

endmodule

// ==== verilog/dl2_store.sv ====
`timescale 1ns/1ns
module dl2_store import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [ADDR_W-1:0]     adr_i,
	input  logic                  wr_i,
	input  logic [LINE_SEL_W-1:0] wsel_i,
	input  logic [LINE_W-1:0]     wline_i,
	output logic                  hit_o,
	output logic [LINE_W-1:0]     line_o
);

logic [L2_TAG_W-1:0] tag_mem  [L2_LINES];
logic [LINE_W-1:0]   line_mem [L2_LINES];
logic [L2_LINES-1:0] valid;
logic [L2_IDX_W-1:0] idx;
logic [L2_TAG_W-1:0] tag;
logic                tag_hit;
logic                wr_en;

// Read pipeline, one stage per cycle of latency
logic [L2_READ_LAT-1:0] hit_pipe;
logic [LINE_W-1:0]      line_pipe [L2_READ_LAT];

assign idx     = adr_i[LINE_OFF_W +: L2_IDX_W];
assign tag     = adr_i[ADDR_W-1 -: L2_TAG_W];
assign tag_hit = valid[idx] && (tag_mem[idx] == tag);

// Full line writes allocate
// partial writes only land on a resident line
assign wr_en = wr_i && (tag_hit || (&wsel_i));

assign hit_o  = hit_pipe[L2_READ_LAT-1];
assign line_o = line_pipe[L2_READ_LAT-1];

always_ff @(posedge clk) begin
	if (rst_i) begin
		valid    <= '0;
		hit_pipe <= '0;
	end else begin
		if (wr_en)
			valid[idx] <= 1'b1;
		hit_pipe[0] <= tag_hit;
		for (int s = 1; s < L2_READ_LAT; s++)
			hit_pipe[s] <= hit_pipe[s-1];
	end
end

always_ff @(posedge clk) begin
	line_pipe[0] <= line_mem[idx];
	for (int s = 1; s < L2_READ_LAT; s++)
		line_pipe[s] <= line_pipe[s-1];
	if (wr_en) begin
		tag_mem[idx] <= tag;
		for (int b = 0; b < LINE_SEL_W; b++) begin
			if (wsel_i[b])
				line_mem[idx][b*8 +: 8] <= wline_i[b*8 +: 8];
		end
	end
end

endmodule

// ==== verilog/boot_rom.sv ====
`timescale 1ns/1ns
module boot_rom import dcache_pkg::*; (
	input  logic              clk,
	input  logic [ADDR_W-1:0] adr_i,
	output logic [LINE_W-1:0] line_o
);

logic [LINE_W-1:0] rom [ROM_LINES];
logic [ADDR_W-1:0] rom_adr;

// Each word holds the inverse of its own byte address
// Only the lowest ROM_LINES lines of the region are distinct
initial begin
	for (int i = 0; i < ROM_LINES; i++) begin
		for (int w = 0; w < LINE_WORDS; w++) begin
			rom_adr = {ROM_BASE_HI, {(ADDR_W - ROM_HI_W){1'b0}}}
				+ ADDR_W'(i * LINE_SEL_W + w * WORD_BYTES);
			rom[i][w*WORD_W +: WORD_W] = ~rom_adr;
		end
	end
end

// Registered read, one cycle
always_ff @(posedge clk) begin
	line_o <= rom[adr_i[LINE_OFF_W +: ROM_IDX_W]];
end

endmodule

// ==== verilog/dc_controller.sv ====
`timescale 1ns/1ns
module dc_controller import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  rd_i,
	input  logic                  wr_i,
	input  logic [ADDR_W-1:0]     line_adr_i,
	input  logic [OFF_W-1:0]      word_off_i,
	input  logic [LINE_W-1:0]     st_line_i,
	input  logic [LINE_SEL_W-1:0] st_sel_i,
	input  logic                  inv_pend_i,
	input  logic [ADDR_W-1:0]     inv_line_i,
	output logic                  inv_take_o,
	input  logic                  l1_hit_i,
	input  logic [LINE_W-1:0]     l1_line_i,
	output logic                  l1_wr_o,
	output logic                  l1_inv_o,
	output logic [L1_IDX_W-1:0]   l1_index_o,
	output logic [L1_TAG_W-1:0]   l1_tag_o,
	output logic [LINE_W-1:0]     l1_wline_o,
	output logic [LINE_SEL_W-1:0] l1_wsel_o,
	input  logic                  l2_hit_i,
	input  logic [LINE_W-1:0]     l2_line_i,
	output logic                  l2_wr_o,
	output logic [ADDR_W-1:0]     l2_adr_o,
	output logic [LINE_W-1:0]     l2_wline_o,
	output logic [LINE_SEL_W-1:0] l2_wsel_o,
	input  logic [LINE_W-1:0]     rom_line_i,
	output logic                  fetch_o,
	output logic [ADDR_W-1:0]     fetch_adr_o,
	input  logic                  fill_done_i,
	input  logic [LINE_W-1:0]     fill_line_i,
	input  logic                  fill_err_i,
	output logic                  ready_o,
	output logic                  rd_done_o,
	output logic [WORD_W-1:0]     rd_data_o,
	output logic                  rd_err_o,
	output logic [FILL_CNT_W-1:0] fill_cnt_o
);

dc_state_e             state;
dc_state_e             cur;
logic [L2_CNT_W-1:0]   wait_cnt;
logic [LINE_W-1:0]     line_q;
logic                  err_q;
logic                  from_bus;
logic                  is_rom;
logic                  st_ok;
logic [ADDR_W-1:0]     l1_adr;

// A pending invalidate takes over the idle cycle
assign cur        = (state == DC_IDLE && inv_pend_i) ? DC_INVAL : state;
assign ready_o    = (cur == DC_IDLE);
assign inv_take_o = (cur == DC_INVAL);
assign l1_inv_o   = (cur == DC_INVAL);

assign is_rom = (line_adr_i[ADDR_W-1 -: ROM_HI_W] == ROM_BASE_HI);
// ROM region is read only
assign st_ok  = (cur == DC_IDLE) && wr_i && !rd_i && !is_rom;

// L1 port addressed by the invalidate line or the request line
assign l1_adr      = (cur == DC_INVAL) ? inv_line_i : line_adr_i;
assign l1_index_o  = l1_adr[LINE_OFF_W +: L1_IDX_W];
assign l1_tag_o    = l1_adr[ADDR_W-1 -: L1_TAG_W];
assign l2_adr_o    = line_adr_i;
assign fetch_adr_o = line_adr_i;

// ====================
// Line store writes
// ====================
// Stores go to L1 on a hit
// L2 merges them only if the line is resident there
always_comb begin
	l1_wr_o    = st_ok && l1_hit_i;
	l2_wr_o    = st_ok;
	l1_wline_o = st_line_i;
	l1_wsel_o  = st_sel_i;
	l2_wline_o = st_line_i;
	l2_wsel_o  = st_sel_i;
	if (cur == DC_FILL) begin
		l1_wr_o    = 1'b1;
		l2_wr_o    = from_bus;
		l1_wline_o = line_q;
		l1_wsel_o  = '1;
		l2_wline_o = line_q;
		l2_wsel_o  = '1;
	end
end

// ====================
// Main FSM
// ====================
always_ff @(posedge clk) begin
	if (rst_i) begin
		state      <= DC_IDLE;
		wait_cnt   <= '0;
		err_q      <= 1'b0;
		from_bus   <= 1'b0;
		fetch_o    <= 1'b0;
		rd_done_o  <= 1'b0;
		rd_err_o   <= 1'b0;
		fill_cnt_o <= '0;
	end else begin
		fetch_o   <= 1'b0;
		rd_done_o <= 1'b0;
		rd_err_o  <= 1'b0;
		case (cur)
		DC_IDLE: begin
			err_q    <= 1'b0;
			from_bus <= 1'b0;
			wait_cnt <= '0;
			if (rd_i) begin
				if (l1_hit_i)
					state <= DC_DONE;
				else if (is_rom)
					state <= DC_ROM;
				else
					state <= DC_L2_WAIT;
			end
		end
		// Invalidate lands on this edge
		DC_INVAL:    state <= DC_IDLE;
		DC_L2_WAIT: begin
			wait_cnt <= wait_cnt + 1'b1;
			if (wait_cnt == L2_CNT_W'(L2_READ_LAT - 1))
				state <= DC_L2_CHECK;
		end
		DC_L2_CHECK: begin
			if (l2_hit_i) begin
				state <= DC_FILL;
			end else begin
				fetch_o <= 1'b1;
				state   <= DC_BUS;
			end
		end
		DC_ROM:      state <= DC_FILL;
		DC_BUS: begin
			if (fill_done_i) begin
				// Failed fill skips the line write
				err_q    <= fill_err_i;
				from_bus <= !fill_err_i;
				state    <= fill_err_i ? DC_DONE : DC_FILL;
			end
		end
		DC_FILL: begin
			if (from_bus)
				fill_cnt_o <= fill_cnt_o + 1'b1;
			state <= DC_DONE;
		end
		DC_DONE: begin
			rd_done_o <= 1'b1;
			rd_err_o  <= err_q;
			state     <= DC_IDLE;
		end
		default:     state <= DC_IDLE;
		endcase
	end
end

// Line capture from whichever source answered
always_ff @(posedge clk) begin
	case (cur)
	DC_IDLE:     line_q <= l1_line_i;
	DC_L2_CHECK: line_q <= l2_line_i;
	DC_ROM:      line_q <= rom_line_i;
	DC_BUS:      line_q <= fill_line_i;
	default:     line_q <= line_q;
	endcase
	if (cur == DC_DONE)
		rd_data_o <= err_q ? '0 : line_q[word_off_i*WORD_W +: WORD_W];
end

endmodule

// ==== verilog/bus_burst_master.sv ====
`timescale 1ns/1ns
module bus_burst_master import dcache_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              fetch_i,
	input  logic [ADDR_W-1:0] fetch_adr_i,
	output logic              fill_done_o,
	output logic [LINE_W-1:0] fill_line_o,
	output logic              fill_err_o,
	output logic              cyc_o,
	output logic              stb_o,
	output cti_e              cti_o,
	output logic [ADDR_W-1:0] adr_o,
	input  logic              ack_i,
	input  logic              err_i,
	input  logic [WORD_W-1:0] dat_i
);

logic [OFF_W-1:0] beat;
logic             beat_end;
logic             last_beat;

// Beat finishes on ack or err while strobing
assign beat_end  = stb_o && (ack_i || err_i);
assign last_beat = (beat == OFF_W'(LINE_WORDS - 1));

// ====================
// Burst control
// ====================
always_ff @(posedge clk) begin
	if (rst_i) begin
		cyc_o       <= 1'b0;
		stb_o       <= 1'b0;
		cti_o       <= CTI_CLASSIC;
		beat        <= '0;
		fill_done_o <= 1'b0;
		fill_err_o  <= 1'b0;
	end else begin
		fill_done_o <= 1'b0;
		if (!cyc_o) begin
			if (fetch_i) begin
				cyc_o      <= 1'b1;
				stb_o      <= 1'b1;
				cti_o      <= CTI_INCR;
				beat       <= '0;
				fill_err_o <= 1'b0;
			end
		end else if (beat_end) begin
			if (err_i || last_beat) begin
				// Cycle ends at once on an error
				cyc_o       <= 1'b0;
				stb_o       <= 1'b0;
				cti_o       <= CTI_CLASSIC;
				fill_done_o <= 1'b1;
				fill_err_o  <= err_i;
			end else begin
				beat  <= beat + 1'b1;
				cti_o <= (beat == OFF_W'(LINE_WORDS - 2)) ? CTI_END : CTI_INCR;
			end
		end
	end
end

// Address stepping and line assembly
// Held while the slave withholds ack
always_ff @(posedge clk) begin
	if (!cyc_o && fetch_i)
		adr_o <= fetch_adr_i;
	else if (beat_end && !err_i)
		adr_o <= adr_o + ADDR_W'(WORD_BYTES);
	if (beat_end && !err_i)
		fill_line_o[beat*WORD_W +: WORD_W] <= dat_i;
end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ns
module dcache_top import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	// Core port
	input  logic                  rd_i,
	input  logic                  wr_i,
	input  logic [ADDR_W-1:0]     adr_i,
	input  logic [WORD_W-1:0]     wdat_i,
	input  logic [WORD_BYTES-1:0] wsel_i,
	input  logic                  inv_i,
	input  logic [ADDR_W-1:0]     inv_adr_i,
	output logic                  ready_o,
	output logic                  rd_done_o,
	output logic [WORD_W-1:0]     rd_data_o,
	output logic                  rd_err_o,
	output logic [FILL_CNT_W-1:0] fill_cnt_o,
	// Read bus
	output logic                  cyc_o,
	output logic                  stb_o,
	output cti_e                  cti_o,
	output logic [ADDR_W-1:0]     adr_o,
	input  logic                  ack_i,
	input  logic                  err_i,
	input  logic [WORD_W-1:0]     dat_i
);

logic [ADDR_W-1:0]     line_adr, inv_line, l2_adr, fetch_adr;
logic [OFF_W-1:0]      word_off;
logic [LINE_W-1:0]     st_line, l1_line, l1_wline, l2_line, l2_wline, rom_line, fill_line;
logic [LINE_SEL_W-1:0] st_sel, l1_wsel, l2_wsel;
logic                  inv_pend, inv_take, l1_hit, l1_wr, l1_inv, l2_hit, l2_wr;
logic                  fetch, fill_done, fill_err;
logic [L1_IDX_W-1:0]   l1_index;
logic [L1_TAG_W-1:0]   l1_tag;

dc_request_stage u_req (
	.clk, .rst_i, .adr_i, .wdat_i, .wsel_i, .inv_i, .inv_adr_i,
	.inv_take_i(inv_take), .line_adr_o(line_adr), .word_off_o(word_off),
	.st_line_o(st_line), .st_sel_o(st_sel), .inv_pend_o(inv_pend), .inv_line_o(inv_line)
);

dc_controller u_ctrl (
	.clk, .rst_i, .rd_i, .wr_i, .line_adr_i(line_adr), .word_off_i(word_off),
	.st_line_i(st_line), .st_sel_i(st_sel), .inv_pend_i(inv_pend), .inv_line_i(inv_line),
	.inv_take_o(inv_take), .l1_hit_i(l1_hit), .l1_line_i(l1_line), .l1_wr_o(l1_wr),
	.l1_inv_o(l1_inv), .l1_index_o(l1_index), .l1_tag_o(l1_tag), .l1_wline_o(l1_wline),
	.l1_wsel_o(l1_wsel), .l2_hit_i(l2_hit), .l2_line_i(l2_line), .l2_wr_o(l2_wr),
	.l2_adr_o(l2_adr), .l2_wline_o(l2_wline), .l2_wsel_o(l2_wsel), .rom_line_i(rom_line),
	.fetch_o(fetch), .fetch_adr_o(fetch_adr), .fill_done_i(fill_done),
	.fill_line_i(fill_line), .fill_err_i(fill_err), .ready_o, .rd_done_o, .rd_data_o,
	.rd_err_o, .fill_cnt_o
);

dl1_store u_l1 (
	.clk, .rst_i, .index_i(l1_index), .tag_i(l1_tag), .wr_i(l1_wr), .wsel_i(l1_wsel),
	.wline_i(l1_wline), .inv_i(l1_inv), .hit_o(l1_hit), .line_o(l1_line)
);

dl2_store u_l2 (
	.clk, .rst_i, .adr_i(l2_adr), .wr_i(l2_wr), .wsel_i(l2_wsel), .wline_i(l2_wline),
	.hit_o(l2_hit), .line_o(l2_line)
);

boot_rom u_rom (.clk, .adr_i(line_adr), .line_o(rom_line));

bus_burst_master u_bus (
	.clk, .rst_i, .fetch_i(fetch), .fetch_adr_i(fetch_adr), .fill_done_o(fill_done),
	.fill_line_o(fill_line), .fill_err_o(fill_err), .cyc_o, .stb_o, .cti_o, .adr_o,
	.ack_i, .err_i, .dat_i
);

endmodule

// ==== test/dcache_bus_chk.sv ====
`timescale 1ns/1ns
module dcache_bus_chk import dcache_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              cyc_o,
	input  logic              stb_o,
	input  cti_e              cti_o,
	input  logic [ADDR_W-1:0] adr_o,
	input  logic              ack_i,
	input  logic              err_i
);

// Failed assertions, read by the testbench top
int unsigned fail_cnt = 0;
// Beats completed in the current cycle
logic [2:0]  beats;

always_ff @(posedge clk) begin
	if (rst_i || !cyc_o)
		beats <= '0;
	else if (stb_o && (ack_i || err_i))
		beats <= beats + 1'b1;
end

// ====================
// Bus protocol
// ====================
a_stb_cyc: assert property (@(posedge clk) disable iff (rst_i) stb_o |-> cyc_o)
	else begin
		fail_cnt++;
		$error("stb_o high without cyc_o");
	end

// Waiting beat holds its address and cycle type
a_hold: assert property (@(posedge clk) disable iff (rst_i)
	stb_o && !ack_i && !err_i |=> stb_o && $stable(adr_o) && $stable(cti_o))
	else begin
		fail_cnt++;
		$error("Beat changed while waiting for ack");
	end

a_max_beats: assert property (@(posedge clk) disable iff (rst_i)
	stb_o && ack_i |-> beats < 3'd4)
	else begin
		fail_cnt++;
		$error("Burst longer than four beats");
	end

a_incr: assert property (@(posedge clk) disable iff (rst_i)
	stb_o && beats < 3'd3 |-> cti_o == CTI_INCR)
	else begin
		fail_cnt++;
		$error("Early beat not marked incrementing");
	end

// Fourth beat is the end of burst, and the cycle closes after it
a_end: assert property (@(posedge clk) disable iff (rst_i)
	stb_o && ack_i && beats == 3'd3 |-> cti_o == CTI_END)
	else begin
		fail_cnt++;
		$error("Last beat not marked end of burst");
	end

a_end_close: assert property (@(posedge clk) disable iff (rst_i)
	stb_o && ack_i && cti_o == CTI_END |=> !cyc_o)
	else begin
		fail_cnt++;
		$error("Cycle still open after end of burst");
	end

endmodule

// ==== test/dcache_monitor.sv ====
`timescale 1ns/1ns
module dcache_monitor import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  rd_i,
	input  logic                  wr_i,
	input  logic [ADDR_W-1:0]     adr_i,
	input  logic [WORD_W-1:0]     wdat_i,
	input  logic [WORD_BYTES-1:0] wsel_i,
	input  logic                  ready_o,
	input  logic                  rd_done_o,
	input  logic [WORD_W-1:0]     rd_data_o,
	input  logic                  rd_err_o,
	input  logic [FILL_CNT_W-1:0] fill_cnt_o,
	input  logic [ADDR_W-1:0]     bad_line_i,
	output int unsigned           chk_cnt_o,
	output int unsigned           err_cnt_o
);

// Shadow words written by stores, keyed by word address
logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];
// Lines that reached L2 through a bus fill
bit                resident [logic [ADDR_W-1:0]];
logic [ADDR_W-1:0] req_adr;
int unsigned       exp_fills;

// ====================
// Reference model
// ====================
// ROM words are the inverted address, bus words are address times 3 plus 1
function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] a);
	logic [ADDR_W-1:0] w;
	w = {a[ADDR_W-1:2], 2'b00};
	if (w[ADDR_W-1 -: 16] == ROM_BASE_HI)
		return ~w;
	if (shadow.exists(w))
		return shadow[w];
	return w * 3 + 1;
endfunction

// Stores only land on lines held by a cache level
task automatic apply_store(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d,
		input logic [WORD_BYTES-1:0] sel);
	logic [ADDR_W-1:0] w;
	logic [WORD_W-1:0] v;
	w = {a[ADDR_W-1:2], 2'b00};
	if (!resident.exists({a[ADDR_W-1:4], 4'h0}))
		return;
	v = ref_word(w);
	for (int b = 0; b < WORD_BYTES; b++) begin
		if (sel[b])
			v[b*8 +: 8] = d[b*8 +: 8];
	end
	shadow[w] = v;
endtask

task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] got);
	if (got !== exp) begin
		err_cnt_o++;
		$display("FAILED %s: address %h expected %h got %h", sig, req_adr, exp, got);
	end
endtask

task automatic check_read();
	logic [ADDR_W-1:0] line;
	logic [WORD_W-1:0] exp_data;
	logic              exp_err;
	line = {req_adr[ADDR_W-1:4], 4'h0};
	chk_cnt_o++;
	if (line == bad_line_i) begin
		exp_err  = 1'b1;
		exp_data = '0;
	end else begin
		exp_err  = 1'b0;
		exp_data = ref_word(req_adr);
		// First touch of a normal line costs one bus fill
		if (req_adr[ADDR_W-1 -: 16] != ROM_BASE_HI && !resident.exists(line)) begin
			resident[line] = 1'b1;
			exp_fills++;
		end
	end
	compare("rd_err_o", 32'(exp_err), 32'(rd_err_o));
	compare("rd_data_o", exp_data, rd_data_o);
	compare("fill_cnt_o", exp_fills, fill_cnt_o);
endtask

// ====================
// Port watcher
// ====================
always @(posedge clk) begin
	if (rst_i) begin
		exp_fills = 0;
		chk_cnt_o = 0;
		err_cnt_o = 0;
	end else begin
		// Finish the old read before taking a new request
		if (rd_done_o)
			check_read();
		if (rd_i && ready_o)
			req_adr = adr_i;
		else if (wr_i && ready_o)
			apply_store(adr_i, wdat_i, wsel_i);
	end
end

endmodule

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ns
module tb_dcache import dcache_pkg::*; ();

localparam int                CLK_PERIOD  = 40;
localparam int                SEED        = 70327;
localparam logic [ADDR_W-1:0] BASE_ADR    = 32'h0000_4000;
localparam int                RANGE_LINES = 32;
localparam logic [ADDR_W-1:0] BAD_LINE    = 32'h0000_8040;
localparam logic [ADDR_W-1:0] ROM_ADR     = 32'hFFFF_0000;
// Operation count bounds the whole run
localparam int                NUM_OPS     = 140;
localparam int                OP_TIMEOUT  = 40;

logic clk, rst_i, rd_i, wr_i, inv_i;
logic [ADDR_W-1:0] adr_i, inv_adr_i, adr_o;
logic [WORD_W-1:0] wdat_i, rd_data_o;
logic [WORD_BYTES-1:0] wsel_i;
logic ready_o, rd_done_o, rd_err_o, cyc_o, stb_o;
logic [FILL_CNT_W-1:0] fill_cnt_o;
cti_e cti_o;
logic ack_i = 1'b0;
logic err_i = 1'b0;
logic [WORD_W-1:0] dat_i = '0;
int unsigned chk_cnt, mon_err, tb_err, err_mark, wait_left;
// Cycles from the accepting edge to the edge that raised rd_done_o
int rd_lat;
integer seed, bus_seed;

dcache_top u_dcache_top (
	.clk, .rst_i, .rd_i, .wr_i, .adr_i, .wdat_i, .wsel_i, .inv_i, .inv_adr_i,
	.ready_o, .rd_done_o, .rd_data_o, .rd_err_o, .fill_cnt_o,
	.cyc_o, .stb_o, .cti_o, .adr_o, .ack_i, .err_i, .dat_i
);

dcache_monitor u_mon (
	.clk, .rst_i, .rd_i, .wr_i, .adr_i, .wdat_i, .wsel_i, .ready_o, .rd_done_o,
	.rd_data_o, .rd_err_o, .fill_cnt_o, .bad_line_i(BAD_LINE),
	.chk_cnt_o(chk_cnt), .err_cnt_o(mon_err)
);

bind bus_burst_master dcache_bus_chk u_bus_chk (
	.clk, .rst_i, .cyc_o, .stb_o, .cti_o, .adr_o, .ack_i, .err_i
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// ====================
// Bus slave model
// ====================
// Random wait states, error on the second beat of the bad line
always @(posedge clk) begin
	if (rst_i) begin
		ack_i     <= 1'b0;
		err_i     <= 1'b0;
		wait_left <= 0;
	end else if (stb_o && (ack_i || err_i)) begin
		ack_i     <= 1'b0;
		err_i     <= 1'b0;
		wait_left <= $unsigned($random(bus_seed)) % 3;
	end else if (stb_o) begin
		if (wait_left != 0)
			wait_left <= wait_left - 1;
		else if ({adr_o[ADDR_W-1:4], 4'h0} == BAD_LINE && adr_o[3:2] == 2'd1)
			err_i <= 1'b1;
		else begin
			ack_i <= 1'b1;
			dat_i <= adr_o * 3 + 1;
		end
	end
end

function automatic int unsigned total_errors();
	return mon_err + tb_err + u_dcache_top.u_bus.u_bus_chk.fail_cnt;
endfunction

// Word aligned address inside the test range
function automatic logic [ADDR_W-1:0] rand_adr();
	logic [ADDR_W-1:0] off;
	off = $unsigned($random(seed)) % (RANGE_LINES * 16);
	return BASE_ADR + {off[ADDR_W-1:2], 2'b00};
endfunction

// Request stays up until an edge where ready_o was high
task automatic wait_accept();
	@(negedge clk);
	while (!ready_o)
		@(negedge clk);
	@(posedge clk);
endtask

task automatic read_word(input logic [ADDR_W-1:0] a);
	int n;
	@(posedge clk);
	rd_i  <= 1'b1;
	adr_i <= a;
	wait_accept();
	rd_i <= 1'b0;
	n = 0;
	while (!rd_done_o && n < OP_TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	rd_lat = n - 1;
	if (!rd_done_o) begin
		tb_err++;
		$display("Timeout: read of address %h never finished", a);
	end
endtask

task automatic write_word(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d,
		input logic [WORD_BYTES-1:0] sel);
	@(posedge clk);
	wr_i   <= 1'b1;
	adr_i  <= a;
	wdat_i <= d;
	wsel_i <= sel;
	wait_accept();
	wr_i <= 1'b0;
endtask

// Compares ready_o in the middle of the next cycle
task automatic check_ready(input logic exp, input string phase);
	@(negedge clk);
	if (ready_o !== exp) begin
		tb_err++;
		$display("FAILED ready_o %s: expected %h got %h", phase, exp, ready_o);
	end
endtask

task automatic invalidate_line(input logic [ADDR_W-1:0] a);
	@(posedge clk);
	inv_i     <= 1'b1;
	inv_adr_i <= a;
	@(posedge clk);
	inv_i <= 1'b0;
	// Latched request holds off the port for exactly one idle cycle
	check_ready(1'b0, "during invalidate");
	check_ready(1'b1, "after invalidate");
endtask

// Lets the monitor finish, then prints one line for the test
task automatic report_test(input int num, input string name);
	int errs;
	repeat (2) @(posedge clk);
	@(negedge clk);
	errs     = total_errors() - err_mark;
	err_mark = total_errors();
	if (errs == 0)
		$display("Test %0d %s: ok", num, name);
	else
		$display("Test %0d %s: %0d errors", num, name, errs);
endtask

// ====================
// Stimulus
// ====================
initial begin
	logic [ADDR_W-1:0] a;
	seed      = SEED;
	bus_seed  = SEED + 1;
	rst_i     = 1'b1;
	rd_i      = 1'b0;
	wr_i      = 1'b0;
	inv_i     = 1'b0;
	adr_i     = '0;
	inv_adr_i = '0;
	wdat_i    = '0;
	wsel_i    = '0;
	tb_err    = 0;
	err_mark  = 0;
	rd_lat    = 0;
	repeat (3) @(posedge clk);
	rst_i <= 1'b0;
	@(posedge clk);

	for (int i = 0; i < RANGE_LINES; i++)
		read_word(BASE_ADR + 32'(i * 16) + 32'((i % 4) * 4));
	report_test(1, "first reads fill from bus");

	for (int i = 0; i < 32; i++)
		read_word(rand_adr());
	report_test(2, "repeated reads");

	// Bit 8 flip gives an L1 conflict line inside the range
	for (int i = 0; i < 8; i++) begin
		a = rand_adr();
		write_word(a, $random(seed), 4'($random(seed)));
		read_word(a);
		read_word(a ^ 32'h100);
		read_word(a);
	end
	report_test(3, "stores merge and survive L1 eviction");

	for (int i = 0; i < 8; i++) begin
		a = rand_adr();
		write_word(a, $random(seed), 4'($random(seed)));
		invalidate_line(a);
		read_word(a);
		// Invalidated line has to come back through the L2 lookup
		if (rd_lat != L2_READ_LAT + 3) begin
			tb_err++;
			$display("Read of %h after invalidate took %0d cycles instead of %0d",
				a, rd_lat, L2_READ_LAT + 3);
		end
	end
	report_test(4, "invalidate then refill from L2");

	for (int i = 0; i < 16; i++)
		read_word(ROM_ADR + (($unsigned($random(seed)) % 256) & 32'hFC));
	report_test(5, "ROM region reads");

	read_word(BAD_LINE + 4);
	read_word(BAD_LINE + 4);
	read_word(BASE_ADR + 8);
	report_test(6, "bus error on bad line");

	$display("Summary: 6 tests, %0d read checks, %0d errors", chk_cnt, total_errors());
	if (total_errors() == 0) begin
		$display("PASS: all tests");
	end else begin
		$display("FAIL: see errors above");
	end
	$finish;
end

// Watchdog sized from the operation count
initial begin
	#(NUM_OPS * OP_TIMEOUT * CLK_PERIOD);
	$display("Watchdog: run did not finish within %0d ns", NUM_OPS * OP_TIMEOUT * CLK_PERIOD);
	$display("FAIL: see errors above");
	$finish;
end

endmodule

// ==== build.f ====
verilog/dcache_pkg.sv
verilog/dc_request_stage.sv
verilog/dl1_store.sv
verilog/dl2_store.sv
verilog/boot_rom.sv
verilog/dc_controller.sv
verilog/bus_burst_master.sv
verilog/dcache_top.sv
test/dcache_bus_chk.sv
test/dcache_monitor.sv
test/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dc_request_stage.sv
  - verilog/dl1_store.sv
  - verilog/dl2_store.sv
  - verilog/boot_rom.sv
  - verilog/dc_controller.sv
  - verilog/bus_burst_master.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - test/dcache_bus_chk.sv
      - test/dcache_monitor.sv
      - test/tb_dcache.sv
